// ==== hw/attn_macros.svh ====
// Attention score dimensions
`ifndef ATTN_MACROS_SVH
`define ATTN_MACROS_SVH

// Matrix dimension, also the number of key lanes
`define ATTN_DIM 8

// Row or column index
`define ATTN_IDX_W 3

// Input data and weights
`define ATTN_IN_W 8

// Q and K entries, 8 products of 16 bits
`define ATTN_QK_W 19

// Score accumulator and output word
`define ATTN_SCORE_W 41

`define ATTN_SCALE_DIV 3

`endif

// ==== hw/attn_pkg.sv ====
// Attention score types
package attn_pkg;

	`include "attn_macros.svh"

	typedef logic signed [`ATTN_IN_W-1:0] data_t;
	typedef logic signed [`ATTN_QK_W-1:0] qk_t;
	typedef logic signed [`ATTN_SCORE_W-1:0] score_t;

	// Feed FSM
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD_Q,
		ST_LOAD_K,
		ST_SCORE
	} attn_state_e;

	// Commands broadcast to the key lanes
	typedef enum logic [1:0] {
		LANE_HOLD,
		LANE_CLEAR,
		LANE_KUPDATE,
		LANE_DOT
	} lane_op_e;

endpackage

// ==== hw/lane_bus_if.sv ====
// Feed to key lane bus
`timescale 1ns/1ps
`include "attn_macros.svh"

interface lane_bus_if import attn_pkg::*; ();

	lane_op_e op;
	logic [`ATTN_IDX_W-1:0] col;
	// Q entry during the score phase
	qk_t coef;
	// Column of X seen by each lane
	data_t x_col [`ATTN_DIM];
	logic last;

	modport feed (
		output op,
		output col,
		output coef,
		output x_col,
		output last
	);

	modport lane (
		input op,
		input col,
		input coef,
		input x_col,
		input last
	);

endinterface

// ==== hw/score_bus_if.sv ====
// Lane to drain score bus
`timescale 1ns/1ps
`include "attn_macros.svh"

interface score_bus_if import attn_pkg::*; ();

	// One finished dot product per lane
	score_t score [`ATTN_DIM];
	logic row_ready;

	modport feed (
		output row_ready
	);

	modport drain (
		input score,
		input row_ready
	);

endinterface

// ==== hw/attn_feed.sv ====
// Input capture and lane sequencing
`timescale 1ns/1ps
`include "attn_macros.svh"

module attn_feed import attn_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic [`ATTN_IDX_W:0] t_rows,
	input  data_t in_data,
	input  data_t w_q,
	lane_bus_if.feed lb,
	score_bus_if.feed sb
);

	attn_state_e state;
	logic [2*`ATTN_IDX_W-1:0] cnt;
	logic [`ATTN_IDX_W:0] t_reg;
	logic [`ATTN_IDX_W:0] t_eff;
	logic [`ATTN_IDX_W-1:0] row;
	logic [`ATTN_IDX_W-1:0] step;
	logic load_x;
	logic cnt_end;
	logic score_end;

	data_t x_mem [`ATTN_DIM][`ATTN_DIM];
	data_t wq_mem [`ATTN_DIM][`ATTN_DIM];
	qk_t q_mem [`ATTN_DIM][`ATTN_DIM];
	qk_t q_sum;

	// Sample counter doubles as row and column index
	assign row = cnt[2*`ATTN_IDX_W-1:`ATTN_IDX_W];
	assign step = cnt[`ATTN_IDX_W-1:0];
	assign cnt_end = (cnt == `ATTN_DIM*`ATTN_DIM-1);
	assign score_end = (step == `ATTN_DIM-1) && ({1'b0, row} == t_reg - 1'b1);

	// Sample 0 is taken in idle, with T straight from the port
	assign load_x = (state == ST_IDLE && in_valid) || state == ST_LOAD_Q;
	assign t_eff = (state == ST_IDLE) ? t_rows : t_reg;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cnt <= '0;
			t_reg <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (in_valid) begin
						state <= ST_LOAD_Q;
						cnt <= cnt + 1'b1;
						t_reg <= t_rows;
					end
				end
				ST_LOAD_Q: begin
					cnt <= cnt + 1'b1;
					if (cnt_end)
						state <= ST_LOAD_K;
				end
				ST_LOAD_K: begin
					cnt <= cnt + 1'b1;
					if (cnt_end)
						state <= ST_SCORE;
				end
				default: begin
					if (score_end) begin
						state <= ST_IDLE;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Rows at or above T are stored as zero
	always_ff @(posedge clk) begin
		if (load_x) begin
			x_mem[row][step] <= ({1'b0, row} < t_eff) ? in_data : '0;
			wq_mem[row][step] <= w_q;
		end
		if (state == ST_LOAD_K)
			q_mem[row][step] <= q_sum;
	end

	// Q[row][step], one entry per key weight cycle
	always_comb begin
		q_sum = '0;
		for (int i = 0; i < `ATTN_DIM; i++)
			q_sum = q_sum + qk_t'(x_mem[row][i]) * qk_t'(wq_mem[i][step]);
	end

	always_comb begin
		lb.op = LANE_HOLD;
		lb.col = step;
		lb.coef = '0;
		lb.last = 1'b0;
		// Lane j needs X[j][row] for its K update
		for (int j = 0; j < `ATTN_DIM; j++)
			lb.x_col[j] = x_mem[j][row];
		case (state)
			ST_IDLE: begin
				if (in_valid)
					lb.op = LANE_CLEAR;
			end
			ST_LOAD_K: lb.op = LANE_KUPDATE;
			ST_SCORE: begin
				lb.op = LANE_DOT;
				lb.coef = q_mem[row][step];
				lb.last = (step == `ATTN_DIM-1);
			end
			default: lb.op = LANE_HOLD;
		endcase
	end

	// Lane sums are valid the cycle after last
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sb.row_ready <= 1'b0;
		else
			sb.row_ready <= (state == ST_SCORE) && (step == `ATTN_DIM-1);
	end

	a_t_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_IDLE && in_valid) |-> (t_rows >= 1 && t_rows <= `ATTN_DIM))
		else $error("t_rows out of range at run start");

	a_load_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_LOAD_Q || state == ST_LOAD_K) |-> in_valid)
		else $error("in_valid dropped during load");

endmodule

// ==== hw/key_lane.sv ====
// Key row store and score MAC
`timescale 1ns/1ps
`include "attn_macros.svh"

module key_lane import attn_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic [`ATTN_IDX_W-1:0] lane_idx,
	input  data_t w_k,
	lane_bus_if.lane lb,
	output score_t score
);

	qk_t k_row [`ATTN_DIM];
	score_t acc;
	score_t prod;
	// Key updates seen in this run
	logic [2*`ATTN_IDX_W:0] kupd_cnt;

	assign prod = score_t'(lb.coef) * score_t'(k_row[lb.col]);

	always_ff @(posedge clk) begin
		case (lb.op)
			LANE_CLEAR: begin
				for (int i = 0; i < `ATTN_DIM; i++)
					k_row[i] <= '0;
			end
			LANE_KUPDATE:
				k_row[lb.col] <= k_row[lb.col] + qk_t'(lb.x_col[lane_idx]) * qk_t'(w_k);
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
			score <= '0;
			kupd_cnt <= '0;
		end else begin
			case (lb.op)
				LANE_CLEAR: begin
					acc <= '0;
					score <= '0;
					kupd_cnt <= '0;
				end
				LANE_KUPDATE: kupd_cnt <= kupd_cnt + 1'b1;
				LANE_DOT: begin
					// Publish on the final step and start the next row from zero
					if (lb.last) begin
						score <= acc + prod;
						acc <= '0;
					end else begin
						acc <= acc + prod;
					end
				end
				default: ;
			endcase
		end
	end

	a_k_done: assert property (@(posedge clk) disable iff (!rst_n)
		(lb.op == LANE_DOT) |-> (kupd_cnt == `ATTN_DIM*`ATTN_DIM))
		else $error("dot product started before K was complete");

endmodule

// ==== hw/score_drain.sv ====
// Score scaling and serializer
`timescale 1ns/1ps
`include "attn_macros.svh"

module score_drain import attn_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	score_bus_if.drain sb,
	output logic out_valid,
	output score_t out_data
);

	// Columns 1 to 7 waiting behind out_data
	score_t pend [`ATTN_DIM-1];
	logic [`ATTN_IDX_W-1:0] remain;

	// Negative scores clamp to zero, others truncate
	function automatic score_t scale(input score_t s);
		if (s < 0)
			return '0;
		else
			return s / `ATTN_SCALE_DIV;
	endfunction

	always_ff @(posedge clk) begin
		if (sb.row_ready) begin
			for (int i = 0; i < `ATTN_DIM-1; i++)
				pend[i] <= scale(sb.score[i+1]);
		end else if (remain != 0) begin
			for (int i = 0; i < `ATTN_DIM-2; i++)
				pend[i] <= pend[i+1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data <= '0;
			remain <= '0;
		end else if (sb.row_ready) begin
			out_valid <= 1'b1;
			out_data <= scale(sb.score[0]);
			remain <= `ATTN_IDX_W'(`ATTN_DIM-1);
		end else if (remain != 0) begin
			out_data <= pend[0];
			remain <= remain - 1'b1;
		end else begin
			out_valid <= 1'b0;
			out_data <= '0;
		end
	end

	// Next row lands exactly as the last column goes out
	a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
		sb.row_ready |-> (remain == 0))
		else $error("score row arrived before previous row drained");

endmodule

// ==== hw/attn_score_top.sv ====
// Attention score top level
`timescale 1ns/1ps
`include "attn_macros.svh"

module attn_score_top import attn_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic [`ATTN_IDX_W:0] t_rows,
	input  data_t in_data,
	input  data_t w_q,
	input  data_t w_k,
	output logic out_valid,
	output score_t out_data
);

	lane_bus_if lb ();
	score_bus_if sb ();

	attn_feed u_feed (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.t_rows   (t_rows),
		.in_data  (in_data),
		.w_q      (w_q),
		.lb       (lb.feed),
		.sb       (sb.feed)
	);

	// One lane per row of K
	for (genvar g = 0; g < `ATTN_DIM; g++) begin : g_lane
		key_lane u_lane (
			.clk      (clk),
			.rst_n    (rst_n),
			.lane_idx (`ATTN_IDX_W'(g)),
			.w_k      (w_k),
			.lb       (lb.lane),
			.score    (sb.score[g])
		);
	end

	score_drain u_drain (
		.clk       (clk),
		.rst_n     (rst_n),
		.sb        (sb.drain),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// ==== verif/attn_tb.sv ====
// Attention score testbench
`timescale 1ns/1ps
`include "attn_macros.svh"

module attn_tb import attn_pkg::*; ();

	localparam int clk_period = 8;
	// Six runs of at most 220 cycles, with about double margin
	localparam int watchdog_cycles = 2500;
	localparam int n = `ATTN_DIM;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [`ATTN_IDX_W:0] t_rows;
	data_t in_data;
	data_t w_q;
	data_t w_k;
	logic out_valid;
	score_t out_data;

	int x_m [n][n];
	int wq_m [n][n];
	int wk_m [n][n];
	longint exp_s [n*n];
	int errors = 0;
	int checks = 0;
	int tests = 0;

	attn_score_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.t_rows    (t_rows),
		.in_data   (in_data),
		.w_q       (w_q),
		.w_k       (w_k),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	always #(clk_period/2) clk = ~clk;

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired, simulation did not finish in time");
		$display("Regression failed");
		$finish;
	end

	// Four-state arguments so that X or Z on a DUT output is caught
	task automatic compare(input string name, input logic signed [63:0] got,
			input logic signed [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		tests++;
		if (errors == errs_at_start)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errs_at_start);
	endtask

	task automatic fill_random();
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				x_m[r][c] = int'($urandom_range(255)) - 128;
				wq_m[r][c] = int'($urandom_range(255)) - 128;
				wk_m[r][c] = int'($urandom_range(255)) - 128;
			end
		end
	endtask

	// Q = X*Wq, K = X*Wk with rows of X at or above T zeroed
	task automatic model_scores(input int t);
		longint x [n][n];
		longint q [n][n];
		longint k [n][n];
		longint s;
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				x[r][c] = (r < t) ? x_m[r][c] : 0;
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				q[r][c] = 0;
				k[r][c] = 0;
				for (int i = 0; i < n; i++) begin
					q[r][c] += x[r][i] * wq_m[i][c];
					k[r][c] += x[r][i] * wk_m[i][c];
				end
			end
		end
		for (int r = 0; r < t; r++) begin
			for (int c = 0; c < n; c++) begin
				s = 0;
				for (int i = 0; i < n; i++)
					s += q[r][i] * k[c][i];
				exp_s[r*n+c] = (s < 0) ? 0 : s / `ATTN_SCALE_DIV;
			end
		end
	endtask

	task automatic run_case(input int t);
		int waited;
		model_scores(t);
		t_rows = 4'(t);
		for (int s = 0; s < 2*n*n; s++) begin
			@(negedge clk);
			in_valid = 1'b1;
			in_data = (s < n*n) ? data_t'(x_m[s/n][s%n]) : '0;
			w_q = (s < n*n) ? data_t'(wq_m[s/n][s%n]) : '0;
			w_k = (s >= n*n) ? data_t'(wk_m[(s-n*n)/n][(s-n*n)%n]) : '0;
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		waited = 0;
		while (!out_valid && waited < 64) begin
			@(negedge clk);
			waited++;
		end
		if (!out_valid) begin
			errors++;
			$display("no output within 64 cycles after the last sample (T=%0d)", t);
			return;
		end
		for (int i = 0; i < t*n; i++) begin
			compare("out_valid", out_valid, 1);
			compare("out_data", out_data, exp_s[i]);
			@(negedge clk);
		end
		compare("out_valid", out_valid, 0);
	endtask

	task automatic reset_idle();
		int e0;
		e0 = errors;
		compare("out_valid", out_valid, 0);
		compare("out_data", out_data, 0);
		repeat (10) begin
			@(negedge clk);
			compare("out_valid", out_valid, 0);
		end
		report_test("reset and idle", e0);
	endtask

	task automatic full_run();
		int e0;
		e0 = errors;
		fill_random();
		run_case(8);
		report_test("full run T=8", e0);
	endtask

	task automatic short_run();
		int e0;
		e0 = errors;
		fill_random();
		run_case(1);
		report_test("short run T=1", e0);
	endtask

	// X and Wq identity, so each score is one signed Wk entry
	task automatic clamp_divide();
		int e0;
		e0 = errors;
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				x_m[r][c] = (r == c) ? 1 : 0;
				wq_m[r][c] = (r == c) ? 1 : 0;
				wk_m[r][c] = r*n + c - 30;
			end
		end
		run_case(8);
		report_test("clamp and divide", e0);
	endtask

	task automatic ignored_rows();
		int e0;
		e0 = errors;
		fill_random();
		for (int r = 3; r < n; r++)
			for (int c = 0; c < n; c++)
				x_m[r][c] = (c % 2) ? 127 : -128;
		run_case(3);
		report_test("ignored rows T=3", e0);
	endtask

	task automatic back_to_back();
		int e0;
		e0 = errors;
		fill_random();
		run_case(5);
		fill_random();
		run_case(2);
		report_test("back-to-back runs", e0);
	endtask

	initial begin
		void'($urandom(32'h40ee_b808));
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		t_rows = '0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		reset_idle();
		full_run();
		short_run();
		clamp_divide();
		ignored_rows();
		back_to_back();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+hw
hw/attn_pkg.sv
hw/lane_bus_if.sv
hw/score_bus_if.sv
hw/attn_feed.sv
hw/key_lane.sv
hw/score_drain.sv
hw/attn_score_top.sv
verif/attn_tb.sv

// ==== Bender.yml ====
package:
  name: attn_score

sources:
  - include_dirs:
      - hw
    files:
      - hw/attn_pkg.sv
      - hw/lane_bus_if.sv
      - hw/score_bus_if.sv
      - hw/attn_feed.sv
      - hw/key_lane.sv
      - hw/score_drain.sv
      - hw/attn_score_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/attn_tb.sv
